// File: common/kyber_arith_pkg.sv
`default_nettype none

package kyber_arith_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Ring parameters
  ////////////////////////////////////////////////////////////////////////////

  // Prime modulus of the Kyber ring
  localparam int KYBER_Q = 3329;
  // Coefficients in one polynomial
  localparam int KYBER_N = 256;
  localparam int IDX_W = $clog2(KYBER_N);

  // Reduced coefficient as stored in memory
  localparam int COEFF_W = 12;
  // Coefficient slot in an output beat
  localparam int OUT_COEFF_W = 16;
  // Full product of two reduced coefficients
  localparam int PROD_W = 2 * COEFF_W;

  typedef logic [COEFF_W-1:0] coeff_t;
  typedef logic [IDX_W-1:0]   coeff_idx_t;

  ////////////////////////////////////////////////////////////////////////////
  // Barrett reduction
  ////////////////////////////////////////////////////////////////////////////

  // Products stay below q*q < 2**24
  localparam int BARRETT_SHIFT = 24;
  // floor(2**24 / q), quotient estimate is low by at most one
  localparam int BARRETT_M = (1 << BARRETT_SHIFT) / KYBER_Q;
  localparam int BARRETT_M_W = $clog2(BARRETT_M + 1);

endpackage

`default_nettype wire

// File: common/pacc_map_pkg.sv
`default_nettype none

package pacc_map_pkg;
  import kyber_arith_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Job and controller encodings
  ////////////////////////////////////////////////////////////////////////////

  // Encryption 0, decryption 1
  typedef enum logic {
    PACC_ENC = 1'b0,
    PACC_DEC = 1'b1
  } pacc_mode_e;

  typedef enum logic [2:0] {
    SEQ_IDLE  = 3'd0,
    SEQ_FETCH = 3'd1,
    SEQ_FLUSH = 3'd2,
    SEQ_DRAIN = 3'd3,
    SEQ_DONE  = 3'd4
  } seq_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Output beats and write address map
  ////////////////////////////////////////////////////////////////////////////

  localparam int BEAT_W = 128;
  localparam int COEFFS_PER_BEAT = 8;
  localparam int BEATS_PER_POLY = 32;
  localparam int BEAT_IDX_W = $clog2(BEATS_PER_POLY);
  localparam int WR_ADDR_W = 8;
  // V in encryption, Mp in decryption
  localparam int V_BASE = 128;
  // Bp row r lands at r * 32
  localparam int BP_STRIDE = 32;

  ////////////////////////////////////////////////////////////////////////////
  // Widths derived from the vector length
  ////////////////////////////////////////////////////////////////////////////

  // Row index, rows 0..K
  function automatic int row_w(int k);
    return $clog2(k + 1);
  endfunction

  // Row memory holds (K+1)*K polynomials
  function automatic int a_addr_w(int k);
    return $clog2((k + 1) * k * KYBER_N);
  endfunction

  // Shared NTT vector holds K polynomials
  function automatic int b_addr_w(int k);
    return $clog2(k * KYBER_N);
  endfunction

endpackage

`default_nettype wire

// File: poly_acc/row_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module row_sequencer
  import kyber_arith_pkg::*;
  import pacc_map_pkg::*;
#(
  parameter int KYBER_K = 2,
  localparam int ROW_W = row_w(KYBER_K),
  localparam int A_ADDR_W = a_addr_w(KYBER_K),
  localparam int B_ADDR_W = b_addr_w(KYBER_K),
  localparam int K_W = (KYBER_K > 1) ? $clog2(KYBER_K) : 1
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             i_start,
  input  wire pacc_mode_e       i_mode,
  input  wire logic             i_mac_idle,
  input  wire logic             i_drain_done,
  output logic                  o_busy,
  output logic                  o_done,
  output logic                  o_rd_en,
  output logic [A_ADDR_W-1:0]   o_a_addr,
  output logic [B_ADDR_W-1:0]   o_b_addr,
  output logic                  o_mac_valid,
  output coeff_idx_t            o_mac_idx,
  output logic                  o_mac_first,
  output logic                  o_drain_start,
  output logic [ROW_W-1:0]      o_row
);

  seq_state_e       state_q;
  pacc_mode_e       mode_q;
  logic [ROW_W-1:0] row_q;
  logic [K_W-1:0]   k_q;
  coeff_idx_t       coeff_q;
  logic             last_row;
  logic             last_read;

  // Decryption stops after row 0, encryption after row K
  assign last_row = (mode_q == PACC_DEC) || (row_q == ROW_W'(KYBER_K));
  // Final coefficient of the final polynomial in the row
  assign last_read = (k_q == K_W'(KYBER_K - 1)) &&
                     (coeff_q == coeff_idx_t'(KYBER_N - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Job and row FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= SEQ_IDLE;
      mode_q        <= PACC_ENC;
      row_q         <= '0;
      k_q           <= '0;
      coeff_q       <= '0;
      o_drain_start <= 1'b0;
    end else begin
      o_drain_start <= 1'b0;
      case (state_q)
        SEQ_IDLE: begin
          // Start only sampled here, so a start while busy is dropped
          if (i_start) begin
            mode_q  <= i_mode;
            row_q   <= '0;
            k_q     <= '0;
            coeff_q <= '0;
            state_q <= SEQ_FETCH;
          end
        end
        SEQ_FETCH: begin
          // One coefficient pair per cycle, coefficient index wraps at N
          coeff_q <= coeff_q + 1'b1;
          if (coeff_q == coeff_idx_t'(KYBER_N - 1)) begin
            k_q <= k_q + 1'b1;
          end
          if (last_read) begin
            k_q     <= '0;
            state_q <= SEQ_FLUSH;
          end
        end
        SEQ_FLUSH: begin
          // Last products still in the MAC pipe
          if (i_mac_idle) begin
            o_drain_start <= 1'b1;
            state_q       <= SEQ_DRAIN;
          end
        end
        SEQ_DRAIN: begin
          if (i_drain_done) begin
            if (last_row) begin
              state_q <= SEQ_DONE;
            end else begin
              row_q   <= row_q + 1'b1;
              state_q <= SEQ_FETCH;
            end
          end
        end
        SEQ_DONE: begin
          state_q <= SEQ_IDLE;
        end
        default: begin
          state_q <= SEQ_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign o_busy  = (state_q != SEQ_IDLE);
  // One cycle, right after the last beat leaves
  assign o_done  = (state_q == SEQ_DONE);
  assign o_rd_en = (state_q == SEQ_FETCH);

  // Row memory: row*K*N + k*N + coefficient
  assign o_a_addr = A_ADDR_W'((row_q * KYBER_K + k_q) * KYBER_N + coeff_q);
  // Shared vector: k*N + coefficient
  assign o_b_addr = B_ADDR_W'(k_q * KYBER_N + coeff_q);

  // MAC tags travel with the read
  assign o_mac_valid = o_rd_en;
  assign o_mac_idx   = coeff_q;
  assign o_mac_first = (k_q == '0);
  assign o_row       = row_q;

  // A fetch pass opens only on an empty MAC pipe
  a_fetch_on_idle_pipe : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_rd_en) |-> $past(i_mac_idle));

endmodule

`default_nettype wire

// File: poly_acc/coeff_mac.sv
`timescale 1ns/100ps
`default_nettype none

module coeff_mac
  import kyber_arith_pkg::*;
  import pacc_map_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    i_valid,
  input  wire coeff_idx_t              i_idx,
  input  wire logic                    i_first,
  input  wire coeff_t                  i_a,
  input  wire coeff_t                  i_b,
  input  wire logic [BEAT_IDX_W-1:0]   i_acc_rd_addr,
  output logic                         o_idle,
  output coeff_t [COEFFS_PER_BEAT-1:0] o_acc_rd_data
);

  localparam int BANK_W = $clog2(COEFFS_PER_BEAT);
  localparam int WIDE_W = PROD_W + BARRETT_M_W;
  localparam int R_W = COEFF_W + 2;

  // Stage valids
  logic s1_v;
  logic s2_v;
  logic s3_v;

  // Index and first-pass tags per stage
  coeff_idx_t s1_idx;
  coeff_idx_t s2_idx;
  coeff_idx_t s3_idx;
  logic       s1_first;
  logic       s2_first;
  logic       s3_first;

  logic [PROD_W-1:0] s2_prod;
  coeff_t            s3_red;
  coeff_t            s3_old;

  // Barrett path
  logic [WIDE_W-1:0]      bar_wide;
  logic [BARRETT_M_W-1:0] bar_quot;
  logic [PROD_W-1:0]      bar_tq;
  logic [R_W-1:0]         bar_r;
  coeff_t                 bar_red;

  logic [COEFF_W:0] acc_sum;
  coeff_t           acc_wr_val;

  // Bank = idx low bits, so one beat reads all 8 banks at once
  coeff_t acc_mem [COEFFS_PER_BEAT][BEATS_PER_POLY];

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_v <= 1'b0;
      s2_v <= 1'b0;
      s3_v <= 1'b0;
    end else begin
      s1_v <= i_valid;
      s2_v <= s1_v;
      s3_v <= s2_v;
    end
  end

  // Nothing in flight, including the read just issued
  assign o_idle = !(i_valid || s1_v || s2_v || s3_v);

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  // Product times floor(2**24/q), shifted down gives the quotient
  assign bar_wide = s2_prod * BARRETT_M_W'(BARRETT_M);
  assign bar_quot = bar_wide[BARRETT_SHIFT +: BARRETT_M_W];
  assign bar_tq   = PROD_W'(bar_quot * KYBER_Q);
  // Remainder below 2q
  assign bar_r    = R_W'(s2_prod - bar_tq);
  assign bar_red  = (bar_r >= R_W'(KYBER_Q)) ? coeff_t'(bar_r - R_W'(KYBER_Q))
                                             : coeff_t'(bar_r);

  // Later passes add onto the stored partial sum
  assign acc_sum = s3_red + s3_old;
  assign acc_wr_val = s3_first ? s3_red :
                      (acc_sum >= (COEFF_W + 1)'(KYBER_Q)) ?
                      coeff_t'(acc_sum - (COEFF_W + 1)'(KYBER_Q)) : coeff_t'(acc_sum);

  always_ff @(posedge clk) begin
    // Stage 1 lines up with the memory data
    s1_idx   <= i_idx;
    s1_first <= i_first;
    // Stage 2 holds the raw product
    s2_idx   <= s1_idx;
    s2_first <= s1_first;
    s2_prod  <= i_a * i_b;
    // Stage 3 holds reduction and old value
    s3_idx   <= s2_idx;
    s3_first <= s2_first;
    s3_red   <= bar_red;
    s3_old   <= acc_mem[s2_idx[BANK_W-1:0]][s2_idx[IDX_W-1:BANK_W]];
  end

  // Same index returns only N cycles later, no write hazard
  always_ff @(posedge clk) begin
    if (s3_v) begin
      acc_mem[s3_idx[BANK_W-1:0]][s3_idx[IDX_W-1:BANK_W]] <= acc_wr_val;
    end
  end

  // Beat read for the packer, one cycle latency
  always_ff @(posedge clk) begin
    for (int j = 0; j < COEFFS_PER_BEAT; j++) begin
      o_acc_rd_data[j] <= acc_mem[j][i_acc_rd_addr];
    end
  end

  // Written value stays in [0,q) across all passes
  a_wr_below_q : assert property (@(posedge clk) disable iff (!rst_n)
    s3_v |-> (acc_wr_val < coeff_t'(KYBER_Q)));

endmodule

`default_nettype wire

// File: poly_acc/beat_packer.sv
`timescale 1ns/100ps
`default_nettype none

module beat_packer
  import kyber_arith_pkg::*;
  import pacc_map_pkg::*;
#(
  parameter int KYBER_K = 2,
  parameter int INIT_CREDITS = 4,
  localparam int ROW_W = row_w(KYBER_K),
  localparam int CREDIT_W = $clog2(INIT_CREDITS + 1)
) (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         i_drain_start,
  input  wire logic [ROW_W-1:0]             i_row,
  input  wire coeff_t [COEFFS_PER_BEAT-1:0] i_acc_rd_data,
  input  wire logic                         i_credit_return,
  output logic [BEAT_IDX_W-1:0]             o_acc_rd_addr,
  output logic                              o_drain_done,
  output logic                              o_wr_valid,
  output logic [WR_ADDR_W-1:0]              o_wr_addr,
  output logic [BEAT_W-1:0]                 o_wr_data
);

  logic                  active_q;
  logic [BEAT_IDX_W-1:0] rd_beat_q;
  // Read issued last cycle, data now on i_acc_rd_data
  logic                  rd_v_q;
  logic [BEAT_IDX_W-1:0] rd_beat_d1;
  logic [WR_ADDR_W-1:0]  base_q;
  logic [CREDIT_W-1:0]   credit_q;
  logic [CREDIT_W-1:0]   in_flight;
  logic                  issue;

  // Beats read but not yet sent
  assign in_flight = CREDIT_W'(rd_v_q) + CREDIT_W'(o_wr_valid);
  // Read only when a credit is free for it, so the pipe never stalls
  assign issue = active_q && (credit_q > in_flight);
  assign o_acc_rd_addr = rd_beat_q;
  // Bases are multiples of 32, low bits give the beat index
  assign o_drain_done = o_wr_valid && (o_wr_addr[BEAT_IDX_W-1:0] == '1);

  ////////////////////////////////////////////////////////////////////////////
  // Beat counter and credits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q   <= 1'b0;
      rd_beat_q  <= '0;
      rd_v_q     <= 1'b0;
      o_wr_valid <= 1'b0;
      credit_q   <= CREDIT_W'(INIT_CREDITS);
    end else begin
      if (i_drain_start) begin
        active_q  <= 1'b1;
        rd_beat_q <= '0;
      end else if (issue) begin
        rd_beat_q <= rd_beat_q + 1'b1;
        if (rd_beat_q == '1) begin
          active_q <= 1'b0;
        end
      end
      rd_v_q     <= issue;
      o_wr_valid <= rd_v_q;
      // Sent beat takes one, sink pulse gives one back
      credit_q   <= credit_q - CREDIT_W'(o_wr_valid) + CREDIT_W'(i_credit_return);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address and data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // Row 0 is V or Mp, others are Bp rows
    if (i_drain_start) begin
      base_q <= (i_row == '0) ? WR_ADDR_W'(V_BASE) : WR_ADDR_W'(BP_STRIDE * i_row);
    end
    rd_beat_d1 <= rd_beat_q;
    if (rd_v_q) begin
      o_wr_addr <= base_q + WR_ADDR_W'(rd_beat_d1);
      // Coefficient 0 in the low slot, zero-extended
      for (int j = 0; j < COEFFS_PER_BEAT; j++) begin
        o_wr_data[j*OUT_COEFF_W +: OUT_COEFF_W] <= OUT_COEFF_W'(i_acc_rd_data[j]);
      end
    end
  end

  a_valid_has_credit : assert property (@(posedge clk) disable iff (!rst_n)
    o_wr_valid |-> (credit_q != '0));

  // Sink never returns more than it was sent
  a_credit_bound : assert property (@(posedge clk) disable iff (!rst_n)
    credit_q <= CREDIT_W'(INIT_CREDITS));

endmodule

`default_nettype wire

// File: src/pacc_top.sv
`timescale 1ns/100ps
`default_nettype none

module pacc_top
  import kyber_arith_pkg::*;
  import pacc_map_pkg::*;
#(
  parameter int KYBER_K = 2,
  parameter int INIT_CREDITS = 4,
  localparam int ROW_W = row_w(KYBER_K),
  localparam int A_ADDR_W = a_addr_w(KYBER_K),
  localparam int B_ADDR_W = b_addr_w(KYBER_K)
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 i_start,
  input  wire pacc_mode_e           i_mode,
  input  wire coeff_t               i_a_data,
  input  wire coeff_t               i_b_data,
  input  wire logic                 i_credit_return,
  output logic                      o_busy,
  output logic                      o_done,
  output logic                      o_rd_en,
  output logic [A_ADDR_W-1:0]       o_a_addr,
  output logic [B_ADDR_W-1:0]       o_b_addr,
  output logic                      o_wr_valid,
  output logic [WR_ADDR_W-1:0]      o_wr_addr,
  output logic [BEAT_W-1:0]         o_wr_data
);

  // Sequencer to MAC, aligned with the read enable
  logic       mac_valid;
  coeff_idx_t mac_idx;
  logic       mac_first;
  logic       mac_idle;

  // Sequencer to packer handshake
  logic             drain_start;
  logic             drain_done;
  logic [ROW_W-1:0] row;

  // Packer reads the accumulator one beat at a time
  logic [BEAT_IDX_W-1:0]             acc_rd_addr;
  coeff_t [COEFFS_PER_BEAT-1:0]      acc_rd_data;

  row_sequencer #(
    .KYBER_K (KYBER_K)
  ) u_row_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_start       (i_start),
    .i_mode        (i_mode),
    .i_mac_idle    (mac_idle),
    .i_drain_done  (drain_done),
    .o_busy        (o_busy),
    .o_done        (o_done),
    .o_rd_en       (o_rd_en),
    .o_a_addr      (o_a_addr),
    .o_b_addr      (o_b_addr),
    .o_mac_valid   (mac_valid),
    .o_mac_idx     (mac_idx),
    .o_mac_first   (mac_first),
    .o_drain_start (drain_start),
    .o_row         (row)
  );

  coeff_mac u_coeff_mac (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_valid       (mac_valid),
    .i_idx         (mac_idx),
    .i_first       (mac_first),
    .i_a           (i_a_data),
    .i_b           (i_b_data),
    .i_acc_rd_addr (acc_rd_addr),
    .o_idle        (mac_idle),
    .o_acc_rd_data (acc_rd_data)
  );

  beat_packer #(
    .KYBER_K      (KYBER_K),
    .INIT_CREDITS (INIT_CREDITS)
  ) u_beat_packer (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_drain_start   (drain_start),
    .i_row           (row),
    .i_acc_rd_data   (acc_rd_data),
    .i_credit_return (i_credit_return),
    .o_acc_rd_addr   (acc_rd_addr),
    .o_drain_done    (drain_done),
    .o_wr_valid      (o_wr_valid),
    .o_wr_addr       (o_wr_addr),
    .o_wr_data       (o_wr_data)
  );

endmodule

`default_nettype wire

// File: bench/pacc_model.svh
`ifndef PACC_MODEL_SVH
`define PACC_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference model of the accumulate stage
////////////////////////////////////////////////////////////////////////////

// V and Mp at 128, Bp row r at 32*r
function automatic int expected_addr(input int row, input int beat);
  if (row == 0) begin
    return 128 + beat;
  end
  return 32 * row + beat;
endfunction

// Eight coefficients of one beat, each the sum over k of a*b mod q
function automatic logic [BEAT_W-1:0] expected_beat(input int row, input int beat);
  logic [BEAT_W-1:0] result;
  int                idx;
  int                sum;
  result = '0;
  for (int j = 0; j < 8; j++) begin
    idx = beat * 8 + j;
    sum = 0;
    for (int k = 0; k < KYBER_K; k++) begin
      sum = (sum + int'(a_mem[(row * KYBER_K + k) * KYBER_N + idx]) *
                   int'(b_mem[k * KYBER_N + idx])) % KYBER_Q;
    end
    // Coefficient 0 in the low 16 bits
    result[j*16 +: 16] = 16'(sum);
  end
  return result;
endfunction

// Single compare point for every check in the bench
task automatic check_value(input logic [BEAT_W-1:0] got, input logic [BEAT_W-1:0] exp,
                           input string what);
  if (got !== exp) begin
    fail_count++;
    $display("CHECK FAILED at %0t: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
    $display("Some tests failed");
    $fatal(1, "stopping at first mismatch");
  end
endtask

`endif

// File: bench/tb_pacc.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pacc
  import kyber_arith_pkg::*;
  import pacc_map_pkg::*;
();

  localparam int KYBER_K = 2;
  localparam int INIT_CREDITS = 4;
  localparam int A_ADDR_W = a_addr_w(KYBER_K);
  localparam int B_ADDR_W = b_addr_w(KYBER_K);
  localparam int A_DEPTH = (KYBER_K + 1) * KYBER_K * KYBER_N;
  localparam int B_DEPTH = KYBER_K * KYBER_N;
  localparam int NUM_JOBS = 8;
  // Every job bounded as a full encryption, doubled for slow credit phases
  localparam int WATCHDOG_CYCLES =
    2 * NUM_JOBS * (KYBER_K + 1) * (KYBER_K * KYBER_N + BEATS_PER_POLY * 6);

  logic                 clk;
  logic                 rst_n = 1'b0;
  logic                 i_start = 1'b0;
  pacc_mode_e           i_mode = PACC_ENC;
  coeff_t               i_a_data = '0;
  coeff_t               i_b_data = '0;
  logic                 i_credit_return = 1'b0;
  logic                 o_busy;
  logic                 o_done;
  logic                 o_rd_en;
  logic [A_ADDR_W-1:0]  o_a_addr;
  logic [B_ADDR_W-1:0]  o_b_addr;
  logic                 o_wr_valid;
  logic [WR_ADDR_W-1:0] o_wr_addr;
  logic [BEAT_W-1:0]    o_wr_data;

  // Row memory and shared NTT vector
  coeff_t a_mem [A_DEPTH];
  coeff_t b_mem [B_DEPTH];

  // Beats seen by the sink, and the row/beat order a job should produce
  logic [WR_ADDR_W-1:0] rx_addr [$];
  logic [BEAT_W-1:0]    rx_data [$];
  int                   exp_row [$];
  int                   exp_beat [$];
  int                   due_q [$];
  int                   rx_total = 0;
  int                   outstanding = 0;
  int                   cycle_count = 0;
  int                   fail_count = 0;
  bit                   hold_credits = 1'b0;

  `include "pacc_model.svh"

  pacc_top #(
    .KYBER_K      (KYBER_K),
    .INIT_CREDITS (INIT_CREDITS)
  ) DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_start         (i_start),
    .i_mode          (i_mode),
    .i_a_data        (i_a_data),
    .i_b_data        (i_b_data),
    .i_credit_return (i_credit_return),
    .o_busy          (o_busy),
    .o_done          (o_done),
    .o_rd_en         (o_rd_en),
    .o_a_addr        (o_a_addr),
    .o_b_addr        (o_b_addr),
    .o_wr_valid      (o_wr_valid),
    .o_wr_addr       (o_wr_addr),
    .o_wr_data       (o_wr_data)
  );

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory and credit sink models
  ////////////////////////////////////////////////////////////////////////////

  // Synchronous reads, data one cycle after the enable
  always @(posedge clk) begin : memory_model
    if (o_rd_en) begin
      i_a_data <= a_mem[o_a_addr];
      i_b_data <= b_mem[o_b_addr];
    end
  end

  // Queue beats, hand back one credit per beat after a random delay
  always @(posedge clk) begin : credit_sink
    int delay;
    cycle_count++;
    if (o_wr_valid) begin
      rx_addr.push_back(o_wr_addr);
      rx_data.push_back(o_wr_data);
      rx_total++;
      outstanding++;
      check_value(outstanding <= INIT_CREDITS, 1'b1, "outstanding beats within credits");
      // Long stretches without credit when holding
      delay = hold_credits ? 16 + $urandom % 16 : $urandom % 6;
      due_q.push_back(cycle_count + delay);
    end
    if (due_q.size() > 0 && due_q[0] <= cycle_count) begin
      void'(due_q.pop_front());
      outstanding--;
      i_credit_return <= 1'b1;
    end else begin
      i_credit_return <= 1'b0;
    end
  end

  // Checker samples on the falling edge, away from the sink updates
  initial begin : compare_beats
    logic [WR_ADDR_W-1:0] got_addr;
    logic [BEAT_W-1:0]    got_data;
    int                   row;
    int                   beat;
    forever begin
      @(negedge clk);
      while (rx_addr.size() > 0) begin
        got_addr = rx_addr.pop_front();
        got_data = rx_data.pop_front();
        // Extra or duplicated beat has nothing left to match
        check_value(exp_row.size() > 0, 1'b1, "beat arrived while a job expects one");
        row  = exp_row.pop_front();
        beat = exp_beat.pop_front();
        check_value(got_addr, expected_addr(row, beat), "write address");
        // Range first, so an unreduced coefficient shows up as such
        for (int j = 0; j < COEFFS_PER_BEAT; j++) begin
          check_value(got_data[j*16 +: 16] < 16'(KYBER_Q), 1'b1, "coefficient below q");
        end
        check_value(got_data, expected_beat(row, beat), "beat data");
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run still going after %0d clock cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_random();
    for (int i = 0; i < A_DEPTH; i++) begin
      a_mem[i] = coeff_t'($urandom % KYBER_Q);
    end
    for (int i = 0; i < B_DEPTH; i++) begin
      b_mem[i] = coeff_t'($urandom % KYBER_Q);
    end
  endtask

  // Edge values, same value at every address
  task automatic fill_const(input int value);
    for (int i = 0; i < A_DEPTH; i++) begin
      a_mem[i] = coeff_t'(value);
    end
    for (int i = 0; i < B_DEPTH; i++) begin
      b_mem[i] = coeff_t'(value);
    end
  endtask

  task automatic pulse_start(input pacc_mode_e mode);
    @(posedge clk);
    i_start <= 1'b1;
    i_mode  <= mode;
    @(posedge clk);
    i_start <= 1'b0;
  endtask

  // One job, optionally with a second start while busy
  task automatic run_job(input pacc_mode_e mode, input bit extra_start);
    int rows;
    int first_beat;
    rows = (mode == PACC_DEC) ? 1 : KYBER_K + 1;
    first_beat = rx_total;
    for (int r = 0; r < rows; r++) begin
      for (int b = 0; b < BEATS_PER_POLY; b++) begin
        exp_row.push_back(r);
        exp_beat.push_back(b);
      end
    end
    pulse_start(mode);
    if (extra_start) begin
      repeat (20) @(posedge clk);
      pulse_start((mode == PACC_DEC) ? PACC_ENC : PACC_DEC);
    end
    do @(posedge clk); while (!o_done);
    // Done comes one cycle after the last beat, so every beat is in
    check_value(rx_total - first_beat, rows * BEATS_PER_POLY, "beats in job");
    // No second job hiding behind the first
    repeat (10) begin
      @(posedge clk);
      check_value(o_busy, 1'b0, "busy after done");
    end
  endtask

  initial begin : stimulus
    void'($urandom(32'h0fcdd7cd));
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // Quiet outputs before any start
    repeat (8) begin
      @(posedge clk);
      check_value({o_wr_valid, o_done, o_busy, o_rd_en}, 4'b0, "outputs idle after reset");
    end
    fill_random();
    run_job(PACC_DEC, 1'b0);
    run_job(PACC_ENC, 1'b0);
    // Slow sink
    fill_random();
    hold_credits = 1'b1;
    run_job(PACC_ENC, 1'b0);
    hold_credits = 1'b0;
    fill_const(KYBER_Q - 1);
    run_job(PACC_DEC, 1'b0);
    run_job(PACC_ENC, 1'b0);
    fill_const(0);
    run_job(PACC_ENC, 1'b0);
    // Starts while busy
    fill_random();
    run_job(PACC_ENC, 1'b1);
    run_job(PACC_DEC, 1'b1);
    if (fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+bench
common/kyber_arith_pkg.sv
common/pacc_map_pkg.sv
poly_acc/row_sequencer.sv
poly_acc/coeff_mac.sv
poly_acc/beat_packer.sv
src/pacc_top.sv
bench/tb_pacc.sv

// File: Bender.yml
package:
  name: pacc

sources:
  - files:
      - common/kyber_arith_pkg.sv
      - common/pacc_map_pkg.sv
      - poly_acc/row_sequencer.sv
      - poly_acc/coeff_mac.sv
      - poly_acc/beat_packer.sv
      - src/pacc_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_pacc.sv
